/* logic/flitPkg.sv */
`default_nettype none

package flitPkg;

  // ============================================================
  // flit format
  // ============================================================

  localparam int payloadWidth = 12;

  typedef enum logic [2:0]
  {
    kindNone = 3'b000,
    kindHead = 3'b001, // payload carries packet length in cycles
    kindBody = 3'b010,
    kindTail = 3'b011
  } flitKind_t;

  typedef struct packed
  {
    flitKind_t                 kind;
    logic [payloadWidth-1:0]   payload;
  } flit_t; // 15 bits

endpackage

`default_nettype wire

/* logic/routerPkg.sv */
`default_nettype none

package routerPkg;

  // ============================================================
  // directions and grant encoding
  // ============================================================

  localparam int numDirs = 5;

  // index order doubles as the rotation order
  typedef enum logic [2:0]
  {
    dirLocal = 3'd0,
    dirNorth = 3'd1,
    dirEast  = 3'd2,
    dirWest  = 3'd3,
    dirSouth = 3'd4
  } dir_t;

  typedef logic [numDirs:0] grant_t; // bit 0 idle, bits 1..5 L..S

  localparam grant_t grantIdle = 6'b000001;

  function automatic grant_t dirGrant(input dir_t dir);
    grant_t oneHot;
    oneHot = '0;
    oneHot[int'(dir) + 1] = 1'b1;
    return oneHot;
  endfunction

endpackage

`default_nettype wire

/* logic/portReqIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface portReqIf #(
  parameter int lengthWidth = 12
);

  logic                    req;
  flitPkg::flitKind_t      kind;
  logic [lengthWidth-1:0]  length; // last head payload
  flitPkg::flit_t          flit;

  modport source (output req, output kind, output length, output flit);

  modport arbSink (input req, input length);

  modport muxSink (input req, input flit);

endinterface

`default_nettype wire

/* logic/inputStage.sv */
`timescale 1ns/1ps
`default_nettype none

module inputStage #(
  parameter int lengthWidth = 12
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  flitPkg::flit_t  flitIn,
  portReqIf.source        port
);

  // ============================================================
  // request and flit registers
  // ============================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      port.req  <= 1'b0;
      port.kind <= flitPkg::kindNone;
    end
    else
    begin
      port.req  <= req;
      port.kind <= flitIn.kind;
    end
  end

  always_ff @(posedge clk)
  begin
    port.flit <= flitIn;
  end

  // length only follows head flits, body and tail leave it alone
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      port.length <= '0;
    end
    else if (flitIn.kind == flitPkg::kindHead)
    begin
      port.length <= lengthWidth'(flitIn.payload);
    end
  end

  // a head flit must come with its request, otherwise the arbiter times a stale length
  headHasReq: assert property (@(posedge clk) disable iff (rst)
    (port.kind == flitPkg::kindHead) |-> port.req);

endmodule

`default_nettype wire

/* logic/packetTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module packetTimer #(
  parameter int lengthWidth = 12
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [lengthWidth-1:0]  length,
  input  logic                    run,
  output logic                    timeUp
);

  logic [lengthWidth-1:0] count; // cycles the grant has been held

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0; // any cycle off the grant restarts the packet
    end
  end

  assign timeUp = (count == length);

endmodule

`default_nettype wire

/* logic/outputArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module outputArbiter #(
  parameter int lengthWidth = 12
) (
  input  logic              clk,
  input  logic              rst,
  portReqIf.arbSink         ports [routerPkg::numDirs],
  output routerPkg::grant_t grant
);

  logic [routerPkg::numDirs-1:0] reqVec;
  logic [lengthWidth-1:0]        lengthArr [routerPkg::numDirs];
  logic [routerPkg::numDirs-1:0] run;
  logic [routerPkg::numDirs-1:0] timeUp;
  routerPkg::grant_t             grantNext;

  // first requester among count directions starting at first, wrapping
  function automatic routerPkg::grant_t pickFrom(
    input int                            first,
    input int                            count,
    input logic [routerPkg::numDirs-1:0] reqs
  );
    routerPkg::grant_t pick;
    logic              found;
    int                idx;
    pick  = routerPkg::grantIdle;
    found = 1'b0;
    for (int off = 0; off < count; off++)
    begin
      idx = (first + off) % routerPkg::numDirs;
      if (!found && reqs[idx])
      begin
        pick  = routerPkg::dirGrant(routerPkg::dir_t'(idx));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // ============================================================
  // per-direction timers
  // ============================================================

  for (genvar d = 0; d < routerPkg::numDirs; d++)
  begin : gDir
    assign reqVec[d]    = ports[d].req;
    assign lengthArr[d] = ports[d].length;

    packetTimer #(
      .lengthWidth (lengthWidth)
    ) timer_i (
      .clk    (clk),
      .rst    (rst),
      .length (lengthArr[d]),
      .run    (run[d]),
      .timeUp (timeUp[d])
    );

    // a held grant never outlasts length+1 cycles
    holdLimit: assert property (@(posedge clk) disable iff (rst)
      (grant == routerPkg::dirGrant(routerPkg::dir_t'(d)))
      |-> (timer_i.count <= lengthArr[d]));
  end

  // ============================================================
  // rotating-priority grant FSM
  // ============================================================

  always_comb
  begin
    grantNext = routerPkg::grantIdle; // also recovers from a corrupt state
    run       = '0;
    if (grant == routerPkg::grantIdle)
    begin
      grantNext = pickFrom(int'(routerPkg::dirLocal), routerPkg::numDirs, reqVec);
    end
    else
    begin
      for (int d = 0; d < routerPkg::numDirs; d++)
      begin
        if (grant == routerPkg::dirGrant(routerPkg::dir_t'(d)))
        begin
          if (reqVec[d] && !timeUp[d])
          begin
            grantNext = grant;
            run[d]    = 1'b1;
          end
          else
          begin
            grantNext = pickFrom(d + 1, routerPkg::numDirs - 1, reqVec); // others only
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= routerPkg::grantIdle;
    end
    else
    begin
      grant <= grantNext;
    end
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant));

endmodule

`default_nettype wire

/* logic/outputMux.sv */
`timescale 1ns/1ps
`default_nettype none

module outputMux (
  input  logic              clk,
  input  logic              rst,
  portReqIf.muxSink         ports [routerPkg::numDirs],
  input  routerPkg::grant_t grant,
  output flitPkg::flit_t    outFlit,
  output logic              outValid
);

  flitPkg::flit_t                flitArr [routerPkg::numDirs];
  logic [routerPkg::numDirs-1:0] reqVec;
  flitPkg::flit_t                selFlit;
  logic                          selValid;

  for (genvar d = 0; d < routerPkg::numDirs; d++)
  begin : gDir
    assign flitArr[d] = ports[d].flit;
    assign reqVec[d]  = ports[d].req;
  end

  // idle selects nothing, so ungranted flits never leak out
  always_comb
  begin
    selFlit  = '0;
    selValid = 1'b0;
    for (int d = 0; d < routerPkg::numDirs; d++)
    begin
      if (grant == routerPkg::dirGrant(routerPkg::dir_t'(d)))
      begin
        selFlit  = flitArr[d];
        selValid = reqVec[d];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= selValid;
    end
  end

endmodule

`default_nettype wire

/* logic/switchPort.sv */
`timescale 1ns/1ps
`default_nettype none

module switchPort #(
  parameter int lengthWidth = 12
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              localReq,
  input  logic              northReq,
  input  logic              eastReq,
  input  logic              westReq,
  input  logic              southReq,
  input  flitPkg::flit_t    localFlit,
  input  flitPkg::flit_t    northFlit,
  input  flitPkg::flit_t    eastFlit,
  input  flitPkg::flit_t    westFlit,
  input  flitPkg::flit_t    southFlit,
  output routerPkg::grant_t grant,
  output flitPkg::flit_t    outFlit,
  output logic              outValid
);

  logic [routerPkg::numDirs-1:0] reqVec;
  flitPkg::flit_t                flitVec [routerPkg::numDirs];

  // index order L, N, E, W, S
  assign reqVec  = {southReq, westReq, eastReq, northReq, localReq};
  assign flitVec = '{localFlit, northFlit, eastFlit, westFlit, southFlit};

  portReqIf #(
    .lengthWidth (lengthWidth)
  ) portIf [routerPkg::numDirs] ();

  // ============================================================
  // input side
  // ============================================================

  for (genvar d = 0; d < routerPkg::numDirs; d++)
  begin : gIn
    inputStage #(
      .lengthWidth (lengthWidth)
    ) stage_i (
      .clk    (clk),
      .rst    (rst),
      .req    (reqVec[d]),
      .flitIn (flitVec[d]),
      .port   (portIf[d])
    );
  end

  // ============================================================
  // arbitration and output
  // ============================================================

  outputArbiter #(
    .lengthWidth (lengthWidth)
  ) arbiter_i (
    .clk   (clk),
    .rst   (rst),
    .ports (portIf),
    .grant (grant)
  );

  outputMux mux_i (
    .clk      (clk),
    .rst      (rst),
    .ports    (portIf),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

/* include/switchPortCheck.svh */
`ifndef SWITCH_PORT_CHECK_SVH
`define SWITCH_PORT_CHECK_SVH

// ok comes back low on any mismatch
task automatic checkGrant(
  input  string             label,
  input  routerPkg::grant_t expGrant,
  input  routerPkg::grant_t gotGrant,
  output bit                ok
);
  ok = (gotGrant === expGrant);
  if (!ok)
    $display("error %s grant exp %h got %h", label, expGrant, gotGrant);
endtask

task automatic checkFlit(
  input  string          label,
  input  flitPkg::flit_t expFlit,
  input  logic           expValid,
  input  flitPkg::flit_t gotFlit,
  input  logic           gotValid,
  output bit             ok
);
  bit okFlit;
  bit okValid;
  okFlit  = (gotFlit === expFlit);
  okValid = (gotValid === expValid);
  ok      = okFlit && okValid;
  if (!okFlit)
    $display("error %s outFlit exp %h got %h", label, expFlit, gotFlit);
  if (!okValid)
    $display("error %s outValid exp %h got %h", label, expValid, gotValid);
endtask

`endif

/* test/switchPortTb.sv */
`timescale 1ns/1ps
`default_nettype none

module switchPortTb;

  `include "switchPortCheck.svh"

  localparam int clkPeriod = 8;

  localparam routerPkg::grant_t gIdle  = routerPkg::grantIdle;
  localparam routerPkg::grant_t gLocal = 6'b000010;
  localparam routerPkg::grant_t gNorth = 6'b000100;
  localparam routerPkg::grant_t gEast  = 6'b001000;
  localparam routerPkg::grant_t gWest  = 6'b010000;
  localparam routerPkg::grant_t gSouth = 6'b100000;
  localparam flitPkg::flit_t    idleFlit = '0;

  typedef struct packed
  {
    logic [4:0]           req;      // bit 0 local .. bit 4 south
    flitPkg::flit_t [4:0] flits;
    routerPkg::grant_t    expGrant; // two cycles after the row
    logic                 expValid; // three cycles after the row
    flitPkg::flit_t       expFlit;
  } row_t;

  logic              clk;
  logic              rst;
  logic              localReq;
  logic              northReq;
  logic              eastReq;
  logic              westReq;
  logic              southReq;
  flitPkg::flit_t    localFlit;
  flitPkg::flit_t    northFlit;
  flitPkg::flit_t    eastFlit;
  flitPkg::flit_t    westFlit;
  flitPkg::flit_t    southFlit;
  routerPkg::grant_t grant;
  flitPkg::flit_t    outFlit;
  logic              outValid;

  row_t        rows[$];
  string       labels[$];
  bit          rowBad[$];
  logic [15:0] lfsrState;
  bit          tableReady;
  int          testCount;
  int          failCount;
  int          checkCount;

  switchPort #(
    .lengthWidth (12)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .localReq  (localReq),
    .northReq  (northReq),
    .eastReq   (eastReq),
    .westReq   (westReq),
    .southReq  (southReq),
    .localFlit (localFlit),
    .northFlit (northFlit),
    .eastFlit  (eastFlit),
    .westFlit  (westFlit),
    .southFlit (southFlit),
    .grant     (grant),
    .outFlit   (outFlit),
    .outValid  (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(clkPeriod / 2);
      clk = ~clk;
    end
  end

  // ============================================================
  // stimulus helpers
  // ============================================================

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsrStep();
    logic fb;
    fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic flitPkg::flit_t randomFlit(input flitPkg::flitKind_t kind);
    flitPkg::flit_t f;
    f.kind = kind;
    for (int b = 0; b < flitPkg::payloadWidth; b++)
    begin
      f.payload[b] = lfsrStep(); // one step per payload bit
    end
    return f;
  endfunction

  function automatic flitPkg::flit_t headFlit(input int len);
    flitPkg::flit_t f;
    f.kind    = flitPkg::kindHead;
    f.payload = len[flitPkg::payloadWidth-1:0];
    return f;
  endfunction

  function automatic flitPkg::flit_t bodyFlit();
    return randomFlit(flitPkg::kindBody);
  endfunction

  function automatic flitPkg::flit_t tailFlit();
    return randomFlit(flitPkg::kindTail);
  endfunction

  task automatic addRow(
    input string             label,
    input logic [4:0]        req,
    input flitPkg::flit_t    lf, nf, ef, wf, sf,
    input routerPkg::grant_t expGrant
  );
    row_t r;
    r          = '0;
    r.req      = req;
    r.flits    = {sf, wf, ef, nf, lf};
    r.expGrant = expGrant;
    rows.push_back(r);
    labels.push_back(label);
    rowBad.push_back(1'b0);
  endtask

  // req bits are S W E N L
  task automatic buildTable();
    addRow("idle after reset", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("idle after reset", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("idle after reset", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("idle priority", 5'b10110,
           idleFlit, headFlit(2), headFlit(1), idleFlit, headFlit(0), gNorth);
    addRow("north timer", 5'b10110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, bodyFlit(), gNorth);
    addRow("north timer", 5'b10110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, bodyFlit(), gNorth);
    addRow("north to east", 5'b10110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, bodyFlit(), gEast);
    addRow("east timer", 5'b10110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, bodyFlit(), gEast);
    addRow("east to south", 5'b10110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, bodyFlit(), gSouth);
    addRow("south drops", 5'b00110, idleFlit, bodyFlit(), bodyFlit(), idleFlit, idleFlit, gNorth);
    addRow("north drops", 5'b00100, idleFlit, idleFlit, bodyFlit(), idleFlit, idleFlit, gEast);
    addRow("east holds", 5'b01100, idleFlit, idleFlit, bodyFlit(), headFlit(3), idleFlit, gEast);
    addRow("east drops", 5'b01000, idleFlit, idleFlit, idleFlit, bodyFlit(), idleFlit, gWest);
    addRow("west drops", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("local first", 5'b10001, headFlit(1), idleFlit, idleFlit, idleFlit, headFlit(2), gLocal);
    addRow("local timer", 5'b10001, bodyFlit(), idleFlit, idleFlit, idleFlit, bodyFlit(), gLocal);
    addRow("local to south", 5'b10001, bodyFlit(), idleFlit, idleFlit, idleFlit, bodyFlit(), gSouth);
    addRow("south timer", 5'b10001, bodyFlit(), idleFlit, idleFlit, idleFlit, bodyFlit(), gSouth);
    addRow("south timer", 5'b10001, bodyFlit(), idleFlit, idleFlit, idleFlit, bodyFlit(), gSouth);
    addRow("wrap to local", 5'b00001, bodyFlit(), idleFlit, idleFlit, idleFlit, idleFlit, gLocal);
    addRow("local tail", 5'b00001, tailFlit(), idleFlit, idleFlit, idleFlit, idleFlit, gLocal);
    addRow("local drops", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("idle again", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
    addRow("idle again", 5'b00000, idleFlit, idleFlit, idleFlit, idleFlit, idleFlit, gIdle);
  endtask

  // the mux registers the flit a cycle after the grant settles, so the
  // output seen for a row carries the next row's flit of the granted direction
  task automatic fillOutputs();
    row_t r;
    row_t nextRow;
    for (int i = 0; i < rows.size(); i++)
    begin
      r       = rows[i];
      nextRow = '0;
      if (i + 1 < rows.size())
        nextRow = rows[i + 1];
      for (int d = 0; d < routerPkg::numDirs; d++)
      begin
        if (r.expGrant[d + 1])
        begin
          r.expFlit  = nextRow.flits[d];
          r.expValid = nextRow.req[d];
        end
      end
      rows[i] = r;
    end
  endtask

  task automatic driveRow(input row_t r);
    localReq  = r.req[0];
    northReq  = r.req[1];
    eastReq   = r.req[2];
    westReq   = r.req[3];
    southReq  = r.req[4];
    localFlit = r.flits[0];
    northFlit = r.flits[1];
    eastFlit  = r.flits[2];
    westFlit  = r.flits[3];
    southFlit = r.flits[4];
  endtask

  // ============================================================
  // checks
  // ============================================================

  task automatic checkReset();
    bit okGrant;
    bit okFlit;
    checkGrant("reset", gIdle, grant, okGrant);
    checkFlit("reset", idleFlit, 1'b0, outFlit, outValid, okFlit);
    checkCount += 2;
    testCount++;
    if (!(okGrant && okFlit))
      failCount++;
    $display("test reset state %s", (okGrant && okFlit) ? "passed" : "failed");
  endtask

  task automatic checkGrantRow(input int i);
    bit ok;
    checkCount++;
    checkGrant($sformatf("row %0d", i), rows[i].expGrant, grant, ok);
    if (!ok)
      rowBad[i] = 1'b1;
  endtask

  task automatic checkOutputRow(input int i);
    bit ok;
    checkCount++;
    checkFlit($sformatf("row %0d", i), rows[i].expFlit, rows[i].expValid, outFlit, outValid, ok);
    if (!ok)
      rowBad[i] = 1'b1;
    testCount++;
    if (rowBad[i])
      failCount++;
    $display("test %0d %s %s", i, labels[i], rowBad[i] ? "failed" : "passed");
  endtask

  // ============================================================
  // main sequence and watchdog
  // ============================================================

  initial
  begin
    rst        = 1'b1;
    tableReady = 1'b0;
    testCount  = 0;
    failCount  = 0;
    checkCount = 0;
    lfsrState  = 16'd23;
    driveRow('0);
    buildTable();
    fillOutputs();
    tableReady = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkReset();
    rst = 1'b0;
    for (int i = 0; i < rows.size() + 3; i++)
    begin
      if (i < rows.size())
        driveRow(rows[i]);
      else
        driveRow('0); // flush cycles
      if (i >= 2 && i - 2 < rows.size())
        checkGrantRow(i - 2);
      if (i >= 3)
        checkOutputRow(i - 3);
      @(negedge clk);
    end
    $display("tests %0d, failed %0d, checks %0d", testCount, failCount, checkCount);
    if (failCount == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial
  begin
    wait (tableReady);
    #((rows.size() + 20) * clkPeriod);
    $display("timeout: the table did not finish in the expected number of cycles");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* switchPort.f */
+incdir+include
logic/flitPkg.sv
logic/routerPkg.sv
logic/portReqIf.sv
logic/inputStage.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/outputMux.sv
logic/switchPort.sv
test/switchPortTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := switchPortTb
FILELIST   := switchPort.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_TEXT  := RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
